//--- hw/fas_consts.svh
// Fixed widths and tables for the 16-point chain; coefficients are Q16, changing a width needs a full rebuild
`ifndef FAS_CONSTS_SVH
`define FAS_CONSTS_SVH

//////////////////////////////
// Widths and sizes
//////////////////////////////
`define FAS_SAMPLE_W   16
`define FAS_TAPS       32
`define FAS_COEF_W     20
`define FAS_FIR_ACC_W  42
`define FAS_FRAME_N    16
`define FAS_TW_W       18
`define FAS_FFT_W      21
`define FAS_BIN_IDX_W  4
`define FAS_POWER_W    33

//////////////////////////////
// Low-pass FIR taps, Q16
//////////////////////////////
`define FAS_FIR_C00 20'shFFF9E
`define FAS_FIR_C01 20'shFFF86
`define FAS_FIR_C02 20'shFFFA7
`define FAS_FIR_C03 20'sh0003B
`define FAS_FIR_C04 20'sh0014B
`define FAS_FIR_C05 20'sh0024A
`define FAS_FIR_C06 20'sh00222
`define FAS_FIR_C07 20'shFFFE4
`define FAS_FIR_C08 20'shFFBC5
`define FAS_FIR_C09 20'shFF7CA
`define FAS_FIR_C10 20'shFF74E
`define FAS_FIR_C11 20'shFFD74
`define FAS_FIR_C12 20'sh00B1A
`define FAS_FIR_C13 20'sh01DAC
`define FAS_FIR_C14 20'sh02F9E
`define FAS_FIR_C15 20'sh03AA9
`define FAS_FIR_C16 20'sh03AA9
`define FAS_FIR_C17 20'sh02F9E
`define FAS_FIR_C18 20'sh01DAC
`define FAS_FIR_C19 20'sh00B1A
`define FAS_FIR_C20 20'shFFD74
`define FAS_FIR_C21 20'shFF74E
`define FAS_FIR_C22 20'shFF7CA
`define FAS_FIR_C23 20'shFFBC5
`define FAS_FIR_C24 20'shFFFE4
`define FAS_FIR_C25 20'sh00222
`define FAS_FIR_C26 20'sh0024A
`define FAS_FIR_C27 20'sh0014B
`define FAS_FIR_C28 20'sh0003B
`define FAS_FIR_C29 20'shFFFA7
`define FAS_FIR_C30 20'shFFF86
`define FAS_FIR_C31 20'shFFF9E

//////////////////////////////
// Twiddles W16^k, signed Q16
//////////////////////////////
`define FAS_TW_RE0 18'sh10000
`define FAS_TW_RE1 18'sh0EC83
`define FAS_TW_RE2 18'sh0B504
`define FAS_TW_RE3 18'sh061F7
`define FAS_TW_RE4 18'sh00000
`define FAS_TW_RE5 18'sh39E09
`define FAS_TW_RE6 18'sh34AFC
`define FAS_TW_RE7 18'sh3137D
`define FAS_TW_IM0 18'sh00000
`define FAS_TW_IM1 18'sh39E09
`define FAS_TW_IM2 18'sh34AFC
`define FAS_TW_IM3 18'sh3137D
`define FAS_TW_IM4 18'sh30000
`define FAS_TW_IM5 18'sh3137D
`define FAS_TW_IM6 18'sh34AFC
`define FAS_TW_IM7 18'sh39E09

`endif

//--- hw/fas_pkg.sv
// Vector types shared by the chain; all widths follow fas_consts.svh and are not parameterizable per instance
`include "fas_consts.svh"

package fas_pkg;

  // One raw or filtered sample
  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;

  // Slot i sits at bits [16*i +: 16], oldest sample in slot 0
  typedef logic [`FAS_FRAME_N*`FAS_SAMPLE_W-1:0] frame_t;

  // Real part high, imaginary part low
  typedef logic [2*`FAS_SAMPLE_W-1:0] bin_t;

  // Bin k sits at bits [32*k +: 32], natural order
  typedef logic [`FAS_FRAME_N*2*`FAS_SAMPLE_W-1:0] bin_array_t;

  typedef logic [`FAS_BIN_IDX_W-1:0] bin_idx_t;   // Frequency index

  typedef logic [`FAS_POWER_W-1:0] power_t;       // re^2 + im^2, unsigned

  typedef logic signed [`FAS_FFT_W-1:0] fft_wide_t; // FFT intermediate with growth bits

endpackage

//--- hw/fir_filter.sv
// 32-tap FIR on a strobed stream; silent until 32 samples are in, output rounds toward zero on negatives
`timescale 1ns/1ps
`include "fas_consts.svh"

module fir_filter (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,
  input  fas_pkg::sample_t data,
  output logic             fir_valid,
  output fas_pkg::sample_t fir_d
);

  localparam int TAPS  = `FAS_TAPS;
  localparam int SW    = `FAS_SAMPLE_W;
  localparam int ACC_W = `FAS_FIR_ACC_W;
  localparam int CNT_W = $clog2(TAPS + 1);
  localparam int FRAC  = 16;                // Q16 coefficients

  localparam logic signed [`FAS_COEF_W-1:0] COEF [TAPS] = '{
    `FAS_FIR_C00, `FAS_FIR_C01, `FAS_FIR_C02, `FAS_FIR_C03,
    `FAS_FIR_C04, `FAS_FIR_C05, `FAS_FIR_C06, `FAS_FIR_C07,
    `FAS_FIR_C08, `FAS_FIR_C09, `FAS_FIR_C10, `FAS_FIR_C11,
    `FAS_FIR_C12, `FAS_FIR_C13, `FAS_FIR_C14, `FAS_FIR_C15,
    `FAS_FIR_C16, `FAS_FIR_C17, `FAS_FIR_C18, `FAS_FIR_C19,
    `FAS_FIR_C20, `FAS_FIR_C21, `FAS_FIR_C22, `FAS_FIR_C23,
    `FAS_FIR_C24, `FAS_FIR_C25, `FAS_FIR_C26, `FAS_FIR_C27,
    `FAS_FIR_C28, `FAS_FIR_C29, `FAS_FIR_C30, `FAS_FIR_C31
  };

  fas_pkg::sample_t        hist [TAPS-1];   // Stored samples, hist[0] newest
  fas_pkg::sample_t        tap_line [TAPS]; // Incoming sample plus history
  logic [CNT_W-1:0]        fill_cnt;        // Saturates at TAPS
  logic signed [ACC_W-1:0] acc;
  fas_pkg::sample_t        rounded;

  //////////////////////////////
  // Window and MAC
  //////////////////////////////
  always_comb begin
    tap_line[0] = data;
    for (int i = 1; i < TAPS; i++) begin
      tap_line[i] = hist[i-1];
    end
  end

  always_comb begin
    acc = '0;
    for (int i = 0; i < TAPS; i++) begin
      acc = acc + ACC_W'(tap_line[i]) * ACC_W'(COEF[i]); // Newest x C00
    end
    rounded = acc[FRAC +: SW] + SW'(acc[ACC_W-1]);      // +1 when the sum is negative
  end

  //////////////////////////////
  // Tap line and output
  //////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hist      <= '{default: '0};
      fill_cnt  <= '0;
      fir_valid <= 1'b0;
      fir_d     <= '0;
    end else begin
      fir_valid <= 1'b0;
      if (data_valid) begin
        for (int i = 0; i < TAPS - 1; i++) begin
          hist[i] <= tap_line[i];
        end
        if (fill_cnt != CNT_W'(TAPS)) begin
          fill_cnt <= fill_cnt + 1'b1;
        end
        if (fill_cnt >= CNT_W'(TAPS - 1)) begin // This sample completes a full window
          fir_valid <= 1'b1;
          fir_d     <= rounded;
        end
      end
    end
  end

  a_fir_follows_sample: assert property (
    @(posedge clk) disable iff (rst) fir_valid |-> $past(data_valid)
  ) else $error("fir_valid raised without a sample accepted in the cycle before");

endmodule

//--- hw/frame_collector.sv
// Gathers 16 filtered samples per frame; counting starts at the first sample after reset, no realignment
`timescale 1ns/1ps
`include "fas_consts.svh"

module frame_collector (
  input  logic             clk,
  input  logic             rst,
  input  logic             fir_valid,
  input  fas_pkg::sample_t fir_d,
  output logic             frame_valid,
  output fas_pkg::frame_t  frame
);

  localparam int N  = `FAS_FRAME_N;
  localparam int SW = `FAS_SAMPLE_W;
  localparam int CW = $clog2(N);

  logic [CW-1:0]    slot_cnt;       // Next slot to fill
  fas_pkg::sample_t slot_buf [N-1]; // Last slot goes straight to the frame

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot_cnt    <= '0;
      slot_buf    <= '{default: '0};
      frame_valid <= 1'b0;
      frame       <= '0;
    end else begin
      frame_valid <= 1'b0;
      if (fir_valid) begin
        if (slot_cnt == CW'(N - 1)) begin
          for (int i = 0; i < N - 1; i++) begin
            frame[i*SW +: SW] <= slot_buf[i];
          end
          frame[(N-1)*SW +: SW] <= fir_d;
          frame_valid           <= 1'b1;
        end else begin
          slot_buf[slot_cnt] <= fir_d;
        end
        slot_cnt <= slot_cnt + 1'b1;   // Wraps to slot 0 after the last one
      end
    end
  end

  a_frame_one_cycle: assert property (
    @(posedge clk) disable iff (rst) frame_valid |=> !frame_valid
  ) else $error("frame_valid held high for more than one cycle");

endmodule

//--- hw/fft16.sv
// 16-point DIF FFT, one frame per cycle; no scaling between stages, bins wrap to their low 16 bits
`timescale 1ns/1ps
`include "fas_consts.svh"

module fft16 (
  input  logic                clk,
  input  logic                rst,
  input  logic                frame_valid,
  input  fas_pkg::frame_t     frame,
  output logic                fft_valid,
  output fas_pkg::bin_array_t fft_bins
);

  localparam int N       = `FAS_FRAME_N;
  localparam int SW      = `FAS_SAMPLE_W;
  localparam int STAGES  = $clog2(N);
  localparam int TW_FRAC = `FAS_TW_W - 2;              // Sign and one integer bit
  localparam int PW      = `FAS_FFT_W + `FAS_TW_W + 1;  // Complex product width

  localparam logic signed [`FAS_TW_W-1:0] TW_RE [N/2] = '{
    `FAS_TW_RE0, `FAS_TW_RE1, `FAS_TW_RE2, `FAS_TW_RE3,
    `FAS_TW_RE4, `FAS_TW_RE5, `FAS_TW_RE6, `FAS_TW_RE7
  };
  localparam logic signed [`FAS_TW_W-1:0] TW_IM [N/2] = '{
    `FAS_TW_IM0, `FAS_TW_IM1, `FAS_TW_IM2, `FAS_TW_IM3,
    `FAS_TW_IM4, `FAS_TW_IM5, `FAS_TW_IM6, `FAS_TW_IM7
  };

  fas_pkg::fft_wide_t src_re  [STAGES][N]; // Butterfly inputs per stage
  fas_pkg::fft_wide_t src_im  [STAGES][N];
  fas_pkg::fft_wide_t bf_re   [STAGES][N]; // Butterfly results
  fas_pkg::fft_wide_t bf_im   [STAGES][N];
  fas_pkg::fft_wide_t pipe_re [STAGES][N]; // Stage registers
  fas_pkg::fft_wide_t pipe_im [STAGES][N];
  logic [STAGES-1:0]  pipe_valid;

  function automatic fas_pkg::bin_idx_t bit_rev(input fas_pkg::bin_idx_t k);
    fas_pkg::bin_idx_t r;
    for (int b = 0; b < `FAS_BIN_IDX_W; b++) begin
      r[b] = k[`FAS_BIN_IDX_W-1-b];
    end
    return r;
  endfunction

  //////////////////////////////
  // Butterfly network
  //////////////////////////////
  always_comb begin
    int                 stride;
    int                 step;
    int                 a;
    int                 c;
    int                 w;
    fas_pkg::fft_wide_t dr;
    fas_pkg::fft_wide_t di;
    logic signed [PW-1:0] pr;
    logic signed [PW-1:0] pi;
    for (int i = 0; i < N; i++) begin
      src_re[0][i] = fas_pkg::fft_wide_t'(signed'(frame[i*SW +: SW]));
      src_im[0][i] = '0;                             // Real input frame
    end
    for (int s = 1; s < STAGES; s++) begin
      src_re[s] = pipe_re[s-1];
      src_im[s] = pipe_im[s-1];
    end
    for (int s = 0; s < STAGES; s++) begin
      stride = N >> (s + 1);                          // 8, 4, 2, 1
      step   = 1 << s;                                // Twiddle index step 1, 2, 4, 8
      for (int b = 0; b < N / 2; b++) begin
        a  = (b / stride) * 2 * stride + (b % stride);
        c  = a + stride;
        w  = (b % stride) * step;
        dr = src_re[s][a] - src_re[s][c];
        di = src_im[s][a] - src_im[s][c];
        pr = PW'(dr) * PW'(TW_RE[w]) - PW'(di) * PW'(TW_IM[w]);
        pi = PW'(dr) * PW'(TW_IM[w]) + PW'(di) * PW'(TW_RE[w]);
        bf_re[s][a] = src_re[s][a] + src_re[s][c];    // Upper leg unscaled
        bf_im[s][a] = src_im[s][a] + src_im[s][c];
        bf_re[s][c] = fas_pkg::fft_wide_t'(pr >>> TW_FRAC);
        bf_im[s][c] = fas_pkg::fft_wide_t'(pi >>> TW_FRAC);
      end
    end
  end

  //////////////////////////////
  // Stage and output registers
  //////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pipe_re    <= '{default: '0};
      pipe_im    <= '{default: '0};
      pipe_valid <= '0;
      fft_valid  <= 1'b0;
      fft_bins   <= '0;
    end else begin
      pipe_re    <= bf_re;
      pipe_im    <= bf_im;
      pipe_valid <= {pipe_valid[STAGES-2:0], frame_valid};
      fft_valid  <= pipe_valid[STAGES-1];
      if (pipe_valid[STAGES-1]) begin
        for (int k = 0; k < N; k++) begin                 // Undo bit-reversed order
          fft_bins[k*2*SW +: 2*SW] <= {
            pipe_re[STAGES-1][bit_rev(fas_pkg::bin_idx_t'(k))][SW-1:0],
            pipe_im[STAGES-1][bit_rev(fas_pkg::bin_idx_t'(k))][SW-1:0]
          };
        end
      end
    end
  end

endmodule

//--- hw/peak_bin_finder.sv
// Strongest bin of a 16-bin frame; ties go to the higher index, power is taken from the wrapped 16-bit bins
`timescale 1ns/1ps
`include "fas_consts.svh"

module peak_bin_finder (
  input  logic                clk,
  input  logic                rst,
  input  logic                fft_valid,
  input  fas_pkg::bin_array_t fft_bins,
  output logic                done,
  output fas_pkg::bin_idx_t   freq
);

  localparam int N     = `FAS_FRAME_N;
  localparam int SW    = `FAS_SAMPLE_W;
  localparam int DEPTH = $clog2(N);
  localparam int NODES = 2 * N - 1;
  localparam int LEAF0 = N - 1;           // Leaves hold bins 0..N-1 in order

  // Heap-ordered compare tree, node n has children 2n+1 and 2n+2
  fas_pkg::power_t   node_pwr [NODES];
  fas_pkg::bin_idx_t node_idx [NODES];
  logic [DEPTH-1:0]  vld_pipe;

  function automatic fas_pkg::power_t bin_power(input fas_pkg::bin_t b);
    fas_pkg::sample_t       re;
    fas_pkg::sample_t       im;
    logic signed [2*SW-1:0] sq_re;
    logic signed [2*SW-1:0] sq_im;
    re    = b[2*SW-1:SW];
    im    = b[SW-1:0];
    sq_re = (2*SW)'(re) * (2*SW)'(re);
    sq_im = (2*SW)'(im) * (2*SW)'(im);
    return fas_pkg::power_t'(unsigned'(sq_re)) + fas_pkg::power_t'(unsigned'(sq_im));
  endfunction

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      node_pwr <= '{default: '0};
      node_idx <= '{default: '0};
      vld_pipe <= '0;
      done     <= 1'b0;
    end else begin
      vld_pipe <= {vld_pipe[DEPTH-2:0], fft_valid};
      done     <= vld_pipe[DEPTH-1];
      if (fft_valid) begin                             // Power stage, new frame only
        for (int k = 0; k < N; k++) begin
          node_pwr[LEAF0+k] <= bin_power(fft_bins[k*2*SW +: 2*SW]);
          node_idx[LEAF0+k] <= fas_pkg::bin_idx_t'(k);
        end
      end
      // Every level advances one step per cycle, so frames flow back to back
      for (int n = 0; n < LEAF0; n++) begin
        if (node_pwr[2*n+1] > node_pwr[2*n+2]) begin   // Lower bin only if strictly larger
          node_pwr[n] <= node_pwr[2*n+1];
          node_idx[n] <= node_idx[2*n+1];
        end else begin
          node_pwr[n] <= node_pwr[2*n+2];
          node_idx[n] <= node_idx[2*n+2];
        end
      end
    end
  end

  assign freq = node_idx[0];

endmodule

//--- hw/fas_top.sv
// Frequency-analysis chain FIR, framer, FFT, peak finder; no back-pressure, input must respect the strobe
`timescale 1ns/1ps

module fas_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                data_valid,
  input  fas_pkg::sample_t    data,
  output logic                fir_valid,
  output fas_pkg::sample_t    fir_d,
  output logic                fft_valid,
  output fas_pkg::bin_array_t fft_bins,
  output logic                done,
  output fas_pkg::bin_idx_t   freq
);

  logic            frame_valid;
  fas_pkg::frame_t frame;

  //////////////////////////////
  // Stage chain
  //////////////////////////////
  fir_filter i_fir_filter (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  frame_collector i_frame_collector (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  fft16 i_fft16 (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .frame       (frame),
    .fft_valid   (fft_valid),
    .fft_bins    (fft_bins)
  );

  peak_bin_finder i_peak_bin_finder (
    .clk       (clk),
    .rst       (rst),
    .fft_valid (fft_valid),
    .fft_bins  (fft_bins),
    .done      (done),
    .freq      (freq)
  );

endmodule

//--- testbench/tb_fas.sv
// Testbench for fas_top; fixed LFSR seed, only DC frames get a full bin compare, tone frames check the peak index
`timescale 1ns/1ps
`include "fas_consts.svh"

module tb_fas;

  localparam int SEED   = 40;
  localparam int IDLE   = 10;                 // Quiet cycles after reset
  localparam int N_RAND = 300;                // Random samples, gaps of up to 3 cycles
  localparam int N_DC   = 80;
  localparam int N_TONE = 96;                 // Per tone
  localparam int N_PIPE = 64;                 // Back-to-back samples
  localparam int MARGIN = 100;
  localparam int LIMIT  = 5 + IDLE + 4 * N_RAND + N_DC + 2 * N_TONE + N_PIPE + MARGIN;
  localparam int DC_VAL = 1500;
  localparam int AMP    = 8000;

  logic clk;
  logic rst;
  logic data_valid;
  fas_pkg::sample_t data;
  int in_tag;                                 // 0 random, 1 DC, 2 tone bin 1, 3 tone bin 2
  logic fir_valid;
  fas_pkg::sample_t fir_d;
  logic fft_valid;
  fas_pkg::bin_array_t fft_bins;
  logic done;
  fas_pkg::bin_idx_t freq;

  // Model state
  logic [15:0] lfsr;
  int hist[$];                                // Newest sample first
  int tags[$];
  int tagq[$];
  int valq[$];
  int doneq[$];
  logic seen_data;
  logic exp_fir_valid;
  fas_pkg::sample_t exp_fir_d;
  int exp_fir_tag;
  logic efv;                                  // Expected frame_valid
  logic [9:0] sr;                             // Frame strobe delay line
  int slot;
  int ftag;
  int cur_fft_tag;
  int cur_done_tag;
  fas_pkg::bin_array_t exp_bins;
  int frames;
  int done_cnt;
  int dc_frames;
  int tone_frames;
  int err_val;
  int err_other;
  int cyc;

  const int coef_half[16] = '{-98, -122, -89, 59, 331, 586, 546, -28,
                              -1083, -2102, -2226, -652, 2842, 7596, 12190, 15017};
  const int sine_tbl[16] = '{0, 3827, 7071, 9239, 10000, 9239, 7071, 3827,
                             0, -3827, -7071, -9239, -10000, -9239, -7071, -3827};

  fas_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d),
    .fft_valid  (fft_valid),
    .fft_bins   (fft_bins),
    .done       (done),
    .freq       (freq)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic lfsr_step();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 16'hB400;            // Galois taps 16,14,13,11
    return b;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r[i] = lfsr_step();
    return r;
  endfunction

  function automatic fas_pkg::sample_t fir_expect();
    longint s;
    s = 0;
    for (int i = 0; i < 32; i++) begin
      s += longint'(hist[i]) * longint'((i < 16) ? coef_half[i] : coef_half[31-i]);
    end
    return s[31:16] + {15'b0, s[63]};         // Round negatives up by one
  endfunction

  function automatic int window_tag();
    for (int i = 1; i < 32; i++) if (tags[i] != tags[0]) return 0;
    return tags[0];
  endfunction

  task automatic send(input int v, input int tag, input int gap);
    @(posedge clk);
    data_valid <= 1'b1;
    data       <= fas_pkg::sample_t'(v);
    in_tag     <= tag;
    repeat (gap) begin
      @(posedge clk);
      data_valid <= 1'b0;
    end
  endtask

  //////////////////////////////
  // Clock, reset, watchdog
  //////////////////////////////
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > LIMIT) begin
      $display("Timeout: run exceeded %0d cycles", LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////
  always @(posedge clk or posedge rst) begin
    logic [15:0] dc16;
    if (rst) begin
      hist.delete();
      tags.delete();
      seen_data     <= 1'b0;
      exp_fir_valid <= 1'b0;
      exp_fir_d     <= '0;
      efv           <= 1'b0;
      sr            <= '0;
      slot = 0;
      ftag = 0;
    end else begin
      exp_fir_valid <= 1'b0;
      efv           <= 1'b0;
      sr            <= {sr[8:0], efv};
      if (done) done_cnt++;
      if (data_valid) begin
        seen_data <= 1'b1;
        hist.push_front(int'(data));
        tags.push_front(in_tag);
        if (hist.size() > 32) begin
          void'(hist.pop_back());
          void'(tags.pop_back());
        end
        if (hist.size() == 32) begin
          exp_fir_valid <= 1'b1;
          exp_fir_d     <= fir_expect();
          exp_fir_tag   <= window_tag();
        end
      end
      if (exp_fir_valid) begin                // Slot tracking of the collector
        if (slot == 0) ftag = exp_fir_tag;
        else if (ftag != exp_fir_tag) ftag = 0;
        if (slot == 15) begin
          efv <= 1'b1;
          tagq.push_back(ftag);
          valq.push_back(int'(exp_fir_d));
          doneq.push_back(ftag);
          frames++;
          if (ftag == 1) dc_frames++;
          if (ftag >= 2) tone_frames++;
        end
        slot = (slot + 1) % 16;
      end
      if (sr[3]) begin                        // Frame reaches the FFT output next cycle
        cur_fft_tag <= tagq.pop_front();
        dc16 = 16'(16 * valq.pop_front());
        exp_bins <= fas_pkg::bin_array_t'({dc16, 16'h0000});
      end
      if (sr[8]) cur_done_tag <= doneq.pop_front();
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  a_reset_quiet: assert property (@(posedge clk)
    (rst || !seen_data) |-> (!fir_valid && !fft_valid && !done && freq == 0))
    else begin
      err_other++;
      $display("Outputs active during reset or before the first sample");
    end

  a_fir_strobe: assert property (@(posedge clk) disable iff (rst) fir_valid == exp_fir_valid)
    else begin
      err_val++;
      $display("** Error [fir_valid] expected %0d, actual %0d",
               $sampled(exp_fir_valid), $sampled(fir_valid));
    end

  a_fir_value: assert property (@(posedge clk) disable iff (rst)
    fir_valid |-> fir_d == exp_fir_d)
    else begin
      err_val++;
      $display("** Error [fir_d] expected %0d, actual %0d", $sampled(exp_fir_d), $sampled(fir_d));
    end

  a_fft_timing: assert property (@(posedge clk) disable iff (rst) fft_valid == sr[4])
    else begin
      err_val++;
      $display("** Error [fft_valid] expected %0d, actual %0d", $sampled(sr[4]), $sampled(fft_valid));
    end

  a_done_timing: assert property (@(posedge clk) disable iff (rst) done == sr[9])
    else begin
      err_val++;
      $display("** Error [done] expected %0d, actual %0d", $sampled(sr[9]), $sampled(done));
    end

  a_dc_bins: assert property (@(posedge clk) disable iff (rst)
    (fft_valid && cur_fft_tag == 1) |-> fft_bins == exp_bins)
    else begin
      err_val++;
      $display("** Error [dc_bins] expected %h, actual %h", $sampled(exp_bins), $sampled(fft_bins));
    end

  a_dc_freq: assert property (@(posedge clk) disable iff (rst)
    (done && cur_done_tag == 1) |-> freq == 0)
    else begin
      err_val++;
      $display("** Error [dc_freq] expected 0, actual %0d", $sampled(freq));
    end

  a_tone_freq: assert property (@(posedge clk) disable iff (rst)
    (done && cur_done_tag >= 2) |->
      (freq == 4'(cur_done_tag - 1) || freq == 4'(17 - cur_done_tag)))
    else begin
      err_val++;
      $display("** Error [tone_freq] expected %0d or %0d, actual %0d",
               $sampled(cur_done_tag) - 1, 17 - $sampled(cur_done_tag), $sampled(freq));
    end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    rst = 1'b1;
    data_valid = 1'b0;
    data = '0;
    in_tag = 0;
    lfsr = 16'(SEED);
    cyc = 0;
    frames = 0;
    done_cnt = 0;
    dc_frames = 0;
    tone_frames = 0;
    err_val = 0;
    err_other = 0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (IDLE) @(posedge clk);
    for (int i = 0; i < N_RAND; i++) send(int'($signed(rand_bits(16))), 0, int'(rand_bits(2)));
    for (int i = 0; i < N_DC; i++) send(DC_VAL, 1, 0);
    for (int k = 1; k <= 2; k++) begin
      for (int n = 0; n < N_TONE; n++) send(AMP * sine_tbl[(n * k) % 16] / 10000, k + 1, 0);
    end
    for (int i = 0; i < N_PIPE; i++) send(int'($signed(rand_bits(16))), 0, 0);
    @(posedge clk);
    data_valid <= 1'b0;
    while (sr != 0 || doneq.size() != 0 || exp_fir_valid || efv) @(posedge clk);
    @(posedge clk);
    assert (done_cnt == frames) else begin
      err_other++;
      $display("Frame count mismatch, %0d frames formed but %0d done strobes", frames, done_cnt);
    end
    assert (dc_frames > 0 && tone_frames > 0) else begin
      err_other++;
      $display("Stimulus never formed a full DC frame and tone frames");
    end
    $display("Errors: %0d value, %0d other, %0d frames checked", err_val, err_other, frames);
    if (err_val + err_other == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hw
hw/fas_pkg.sv
hw/fir_filter.sv
hw/frame_collector.sv
hw/fft16.sv
hw/peak_bin_finder.sv
hw/fas_top.sv
testbench/tb_fas.sv

//--- run_sim.sh
#!/bin/sh
# Builds the frequency-analysis testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_fas \
  -o tb_fas

out=$(./obj_dir/tb_fas)
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
  exit 0
else
  exit 1
fi
